// File: common/hawk_pkg.sv
// hawk shared types and width defaults for the page translation engine
package hawk_pkg;

    //////////////////////////////////////////////////////////////////////
    // width defaults
    //////////////////////////////////////////////////////////////////////

    // host page number width, also sets ATT depth
    localparam int HPPA_W_DEF = 8;
    // physical page number width
    localparam int PPA_W_DEF = 6;
    // physical pages, page 0 is the zero page
    localparam int NUM_PAGES_DEF = 16;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // control unit FSM
    typedef enum logic [3:0] {
        IDLE,
        CHK_RD_ACTIVE,
        CHK_WR_ACTIVE,
        RD_LKP_REQ,
        WR_LKP_REQ,
        RD_LOOKUP_ALLOCATE,
        WR_LOOKUP_ALLOCATE
    } cu_state_e;

    // lookup stage FSM
    typedef enum logic [2:0] {
        LK_IDLE,
        LK_READ,
        LK_CHECK,
        LK_ALLOC,
        LK_RESP
    } lkup_state_e;

    // ATT entry status
    typedef enum logic [1:0] {
        ATT_UNMAPPED,
        ATT_ZERO,
        ATT_MAPPED
    } att_sts_e;

endpackage

// File: src/hawk_cpu_port.sv
// hawk cpu port, Wishbone classic slave holding one request for the control unit
`timescale 1ns/1ps

module hawk_cpu_port import hawk_pkg::*; #(
    parameter int HPPA_W = HPPA_W_DEF,
    parameter int PPA_W  = PPA_W_DEF
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // wishbone slave side
    input  logic              cyc,
    input  logic              stb,
    input  logic [HPPA_W-1:0] adr,
    input  logic [31:0]       dat_w,
    output logic [PPA_W-1:0]  dat_r,
    output logic              ack,
    output logic              err,
    // request towards control unit
    output logic              req_valid,
    output logic [HPPA_W-1:0] req_hppa,
    output logic              req_zero,
    // override back from control unit
    input  logic              ovrd_grant,
    input  logic [PPA_W-1:0]  ovrd_ppa,
    input  logic              ovrd_fault
);

    logic accept;

    // new cycle only when idle and not in the ack/err cycle
    // master still holds stb while ack is high
    assign accept = cyc && stb && !req_valid && !ack && !err;

    // request flag and single cycle response strobes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_valid <= 1'b0;
            ack       <= 1'b0;
            err       <= 1'b0;
        end else begin
            ack <= 1'b0;
            err <= 1'b0;
            if (accept) begin
                req_valid <= 1'b1;
            end else if (ovrd_grant) begin
                // grant closes the request
                req_valid <= 1'b0;
                ack       <= !ovrd_fault;
                err       <= ovrd_fault;
            end
        end
    end

    // holding registers
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_hppa <= adr;
            // all zero data marks a zero block
            req_zero <= (dat_w == 32'd0);
        end
        if (ovrd_grant) begin
            dat_r <= ovrd_ppa;
        end
    end

endmodule

// File: ctrl/hawk_ctrl_unit.sv
// hawk control unit, sequences init and serializes cpu lookups with rotating priority
`timescale 1ns/1ps

module hawk_ctrl_unit import hawk_pkg::*; #(
    parameter int HPPA_W = HPPA_W_DEF,
    parameter int PPA_W  = PPA_W_DEF
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // page writer handshake
    input  logic              init_att_done,
    input  logic              init_list_done,
    output logic              init_att,
    output logic              init_list,
    // cpu port requests
    input  logic              rd_req_valid,
    input  logic [HPPA_W-1:0] rd_req_hppa,
    input  logic              wr_req_valid,
    input  logic [HPPA_W-1:0] wr_req_hppa,
    input  logic              wr_req_zero,
    // cpu port overrides
    output logic              rd_ovrd_grant,
    output logic              wr_ovrd_grant,
    output logic [PPA_W-1:0]  ovrd_ppa,
    output logic              ovrd_fault,
    // lookup stage
    input  logic              lkup_ready,
    output logic              lkup_req,
    output logic [HPPA_W-1:0] lkup_hppa,
    output logic              lkup_zero,
    input  logic              trnsl_valid,
    input  logic [PPA_W-1:0]  trnsl_ppa,
    input  logic              trnsl_fault,
    // debug
    output cu_state_e         cu_state
);

    cu_state_e state_q;
    logic      rd_pend;
    logic      wr_pend;
    logic      pick_rd;
    logic      pick_wr;

    //////////////////////////////////////////////////////////////////////
    // arbitration
    //////////////////////////////////////////////////////////////////////

    // port valid drops one cycle after grant, mask that cycle
    assign rd_pend = rd_req_valid && !rd_ovrd_grant;
    assign wr_pend = wr_req_valid && !wr_ovrd_grant;

    // CHK_RD favours read, CHK_WR favours write
    assign pick_rd = rd_pend && ((state_q == CHK_RD_ACTIVE) ||
                                 (state_q == CHK_WR_ACTIVE && !wr_pend));
    assign pick_wr = wr_pend && ((state_q == CHK_WR_ACTIVE) ||
                                 (state_q == CHK_RD_ACTIVE && !rd_pend));

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= IDLE;
            // init runs straight out of reset
            init_att      <= 1'b1;
            init_list     <= 1'b1;
            lkup_req      <= 1'b0;
            rd_ovrd_grant <= 1'b0;
            wr_ovrd_grant <= 1'b0;
        end else begin
            lkup_req      <= 1'b0;
            rd_ovrd_grant <= 1'b0;
            wr_ovrd_grant <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (init_att_done) begin
                        init_att <= 1'b0;
                    end
                    if (init_list_done) begin
                        init_list <= 1'b0;
                    end
                    // no lookups until both sweeps are over
                    if (init_att_done && init_list_done) begin
                        state_q <= CHK_RD_ACTIVE;
                    end
                end
                CHK_RD_ACTIVE, CHK_WR_ACTIVE: begin
                    if (pick_rd) begin
                        state_q <= RD_LKP_REQ;
                    end else if (pick_wr) begin
                        state_q <= WR_LKP_REQ;
                    end
                end
                // hold request until lookup can take it
                RD_LKP_REQ: begin
                    if (lkup_ready) begin
                        lkup_req <= 1'b1;
                        state_q  <= RD_LOOKUP_ALLOCATE;
                    end
                end
                WR_LKP_REQ: begin
                    if (lkup_ready) begin
                        lkup_req <= 1'b1;
                        state_q  <= WR_LOOKUP_ALLOCATE;
                    end
                end
                // answer the port, then rotate priority
                RD_LOOKUP_ALLOCATE: begin
                    if (trnsl_valid) begin
                        rd_ovrd_grant <= 1'b1;
                        state_q       <= CHK_WR_ACTIVE;
                    end
                end
                WR_LOOKUP_ALLOCATE: begin
                    if (trnsl_valid) begin
                        wr_ovrd_grant <= 1'b1;
                        state_q       <= CHK_RD_ACTIVE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // lookup and override payload
    always_ff @(posedge clk_i) begin
        if (pick_rd) begin
            lkup_hppa <= rd_req_hppa;
            // a read carries no data, so it looks up like a zero write
            lkup_zero <= 1'b1;
        end else if (pick_wr) begin
            lkup_hppa <= wr_req_hppa;
            lkup_zero <= wr_req_zero;
        end
        if (trnsl_valid) begin
            ovrd_ppa   <= trnsl_ppa;
            ovrd_fault <= trnsl_fault;
        end
    end

    assign cu_state = state_q;

endmodule

// File: att/hawk_att_lookup.sv
// hawk ATT lookup stage, maps a host page or allocates from the free list
`timescale 1ns/1ps

module hawk_att_lookup import hawk_pkg::*; #(
    parameter int HPPA_W = HPPA_W_DEF,
    parameter int PPA_W  = PPA_W_DEF
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // request from control unit
    input  logic              lkup_req,
    input  logic [HPPA_W-1:0] lkup_hppa,
    input  logic              lkup_zero,
    output logic              lkup_ready,
    output logic              trnsl_valid,
    output logic [PPA_W-1:0]  trnsl_ppa,
    output logic              trnsl_fault,
    // store access
    output logic [HPPA_W-1:0] att_raddr,
    output logic              att_we,
    output logic [HPPA_W-1:0] att_waddr,
    output att_sts_e          att_wsts,
    output logic [PPA_W-1:0]  att_wppa,
    output logic              fl_pop,
    input  att_sts_e          att_rsts,
    input  logic [PPA_W-1:0]  att_rppa,
    input  logic [PPA_W-1:0]  fl_rdata,
    input  logic              fl_empty
);

    lkup_state_e       state_q;
    logic [HPPA_W-1:0] hppa_q;
    logic              zero_q;
    logic              need_alloc;

    assign lkup_ready  = (state_q == LK_IDLE);
    assign trnsl_valid = (state_q == LK_RESP);

    // non-zero access to anything not yet mapped needs a page
    assign need_alloc = !zero_q && (att_rsts != ATT_MAPPED);

    //////////////////////////////////////////////////////////////////////
    // store side
    //////////////////////////////////////////////////////////////////////

    assign att_raddr = hppa_q;
    assign att_waddr = hppa_q;
    // zero mark in check, mapped entry in alloc
    assign att_we    = (state_q == LK_ALLOC) ||
                       (state_q == LK_CHECK && zero_q && att_rsts == ATT_UNMAPPED);
    assign att_wsts  = (state_q == LK_ALLOC) ? ATT_MAPPED : ATT_ZERO;
    assign att_wppa  = (state_q == LK_ALLOC) ? fl_rdata : '0;
    // fifo head is already valid, pop and write same cycle
    assign fl_pop    = (state_q == LK_ALLOC);

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= LK_IDLE;
        end else begin
            case (state_q)
                LK_IDLE: begin
                    if (lkup_req) begin
                        state_q <= LK_READ;
                    end
                end
                // registered read of the entry
                LK_READ:  state_q <= LK_CHECK;
                // empty list ends as fault without alloc
                LK_CHECK: state_q <= (need_alloc && !fl_empty) ? LK_ALLOC : LK_RESP;
                LK_ALLOC: state_q <= LK_RESP;
                LK_RESP:  state_q <= LK_IDLE;
                default:  state_q <= LK_IDLE;
            endcase
        end
    end

    // request and result registers
    always_ff @(posedge clk_i) begin
        if (lkup_req && lkup_ready) begin
            hppa_q <= lkup_hppa;
            zero_q <= lkup_zero;
        end
        if (state_q == LK_CHECK) begin
            // zero entries and faults answer page 0
            trnsl_ppa   <= (att_rsts == ATT_MAPPED) ? att_rppa : '0;
            trnsl_fault <= need_alloc && fl_empty;
        end
        if (state_q == LK_ALLOC) begin
            trnsl_ppa <= fl_rdata;
        end
    end

endmodule

// File: att/hawk_att_store.sv
// hawk ATT store, entry memory with registered read and the free page FIFO
`timescale 1ns/1ps

module hawk_att_store import hawk_pkg::*; #(
    parameter int HPPA_W    = HPPA_W_DEF,
    parameter int PPA_W     = PPA_W_DEF,
    parameter int NUM_PAGES = NUM_PAGES_DEF
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // ATT write and read ports
    input  logic              att_we,
    input  logic [HPPA_W-1:0] att_waddr,
    input  att_sts_e          att_wsts,
    input  logic [PPA_W-1:0]  att_wppa,
    input  logic [HPPA_W-1:0] att_raddr,
    output att_sts_e          att_rsts,
    output logic [PPA_W-1:0]  att_rppa,
    // free list
    input  logic              fl_push,
    input  logic [PPA_W-1:0]  fl_wdata,
    input  logic              fl_pop,
    output logic [PPA_W-1:0]  fl_rdata,
    output logic              fl_empty
);

    localparam int DEPTH = 2 ** HPPA_W;
    localparam int PTR_W = $clog2(NUM_PAGES);

    att_sts_e         sts_mem  [DEPTH];
    logic [PPA_W-1:0] ppa_mem  [DEPTH];
    logic [PPA_W-1:0] fifo_mem [NUM_PAGES];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // pointer wrap for non power of two depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(NUM_PAGES - 1)) ? '0 : p + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // ATT memory
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (att_we) begin
            sts_mem[att_waddr] <= att_wsts;
            ppa_mem[att_waddr] <= att_wppa;
        end
        att_rsts <= sts_mem[att_raddr];
        att_rppa <= ppa_mem[att_raddr];
    end

    //////////////////////////////////////////////////////////////////////
    // free page FIFO
    //////////////////////////////////////////////////////////////////////

    assign do_push  = fl_push && (count != (PTR_W + 1)'(NUM_PAGES));
    assign do_pop   = fl_pop && !fl_empty;
    assign fl_empty = (count == '0);
    // first word fall through
    assign fl_rdata = fifo_mem[rd_ptr];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= fl_wdata;
        end
    end

endmodule

// File: src/hawk_pg_writer.sv
// hawk page writer, clears the ATT and fills the free list after reset
`timescale 1ns/1ps

module hawk_pg_writer import hawk_pkg::*; #(
    parameter int HPPA_W    = HPPA_W_DEF,
    parameter int PPA_W     = PPA_W_DEF,
    parameter int NUM_PAGES = NUM_PAGES_DEF
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              init_att,
    input  logic              init_list,
    output logic              init_att_done,
    output logic              init_list_done,
    output logic              att_we,
    output logic [HPPA_W-1:0] att_waddr,
    output att_sts_e          att_wsts,
    output logic [PPA_W-1:0]  att_wppa,
    output logic              fl_push,
    output logic [PPA_W-1:0]  fl_wdata
);

    logic [HPPA_W-1:0] att_cnt;
    logic [PPA_W-1:0]  pg_cnt;

    // one entry and one page per cycle, both sweeps in parallel
    assign att_we    = init_att && !init_att_done;
    assign att_waddr = att_cnt;
    assign att_wsts  = ATT_UNMAPPED;
    assign att_wppa  = '0;
    assign fl_push   = init_list && !init_list_done;
    assign fl_wdata  = pg_cnt;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            att_cnt        <= '0;
            // page 0 stays off the list
            pg_cnt         <= PPA_W'(1);
            init_att_done  <= 1'b0;
            init_list_done <= 1'b0;
        end else begin
            if (att_we) begin
                att_cnt <= att_cnt + 1'b1;
                if (att_cnt == {HPPA_W{1'b1}}) begin
                    init_att_done <= 1'b1;
                end
            end
            if (fl_push) begin
                pg_cnt <= pg_cnt + 1'b1;
                if (pg_cnt == PPA_W'(NUM_PAGES - 1)) begin
                    init_list_done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: src/hawk_top.sv
// hawk top, two cpu ports, control unit, ATT lookup, store and page writer
`timescale 1ns/1ps

module hawk_top import hawk_pkg::*; #(
    parameter int HPPA_W    = HPPA_W_DEF,
    parameter int PPA_W     = PPA_W_DEF,
    parameter int NUM_PAGES = NUM_PAGES_DEF
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // read port
    input  logic              rd_cyc,
    input  logic              rd_stb,
    input  logic [HPPA_W-1:0] rd_adr,
    output logic [PPA_W-1:0]  rd_dat_r,
    output logic              rd_ack,
    output logic              rd_err,
    // write port
    input  logic              wr_cyc,
    input  logic              wr_stb,
    input  logic [HPPA_W-1:0] wr_adr,
    input  logic [31:0]       wr_dat_w,
    output logic [PPA_W-1:0]  wr_dat_r,
    output logic              wr_ack,
    output logic              wr_err,
    // debug
    output cu_state_e         cu_state
);

    // port to control
    logic              rd_req_valid, wr_req_valid, wr_req_zero;
    logic [HPPA_W-1:0] rd_req_hppa, wr_req_hppa;
    logic              rd_ovrd_grant, wr_ovrd_grant, ovrd_fault;
    logic [PPA_W-1:0]  ovrd_ppa;
    // init handshake
    logic              init_att, init_list, init_att_done, init_list_done;
    // control to lookup
    logic              lkup_ready, lkup_req, lkup_zero;
    logic [HPPA_W-1:0] lkup_hppa;
    logic              trnsl_valid, trnsl_fault;
    logic [PPA_W-1:0]  trnsl_ppa;
    // store ports
    logic [HPPA_W-1:0] att_raddr, att_waddr;
    att_sts_e          att_rsts, att_wsts;
    logic [PPA_W-1:0]  att_rppa, att_wppa;
    logic              att_we;
    logic              fl_push, fl_pop, fl_empty;
    logic [PPA_W-1:0]  fl_wdata, fl_rdata;
    // write side candidates
    logic              lk_att_we, pw_att_we;
    logic [HPPA_W-1:0] lk_att_waddr, pw_att_waddr;
    att_sts_e          lk_att_wsts, pw_att_wsts;
    logic [PPA_W-1:0]  lk_att_wppa, pw_att_wppa;
    logic              init_done;

    //////////////////////////////////////////////////////////////////////
    // cpu ports
    //////////////////////////////////////////////////////////////////////

    // read data tied high, never a zero block
    hawk_cpu_port #(.HPPA_W(HPPA_W), .PPA_W(PPA_W)) i_rd_port (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .cyc        (rd_cyc),
        .stb        (rd_stb),
        .adr        (rd_adr),
        .dat_w      ({32{1'b1}}),
        .dat_r      (rd_dat_r),
        .ack        (rd_ack),
        .err        (rd_err),
        .req_valid  (rd_req_valid),
        .req_hppa   (rd_req_hppa),
        .req_zero   (),
        .ovrd_grant (rd_ovrd_grant),
        .ovrd_ppa   (ovrd_ppa),
        .ovrd_fault (ovrd_fault)
    );

    hawk_cpu_port #(.HPPA_W(HPPA_W), .PPA_W(PPA_W)) i_wr_port (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .cyc        (wr_cyc),
        .stb        (wr_stb),
        .adr        (wr_adr),
        .dat_w      (wr_dat_w),
        .dat_r      (wr_dat_r),
        .ack        (wr_ack),
        .err        (wr_err),
        .req_valid  (wr_req_valid),
        .req_hppa   (wr_req_hppa),
        .req_zero   (wr_req_zero),
        .ovrd_grant (wr_ovrd_grant),
        .ovrd_ppa   (ovrd_ppa),
        .ovrd_fault (ovrd_fault)
    );

    //////////////////////////////////////////////////////////////////////
    // control, lookup, store, init
    //////////////////////////////////////////////////////////////////////

    hawk_ctrl_unit #(.HPPA_W(HPPA_W), .PPA_W(PPA_W)) i_ctrl (.*);

    hawk_att_lookup #(.HPPA_W(HPPA_W), .PPA_W(PPA_W)) i_lookup (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lkup_req    (lkup_req),
        .lkup_hppa   (lkup_hppa),
        .lkup_zero   (lkup_zero),
        .lkup_ready  (lkup_ready),
        .trnsl_valid (trnsl_valid),
        .trnsl_ppa   (trnsl_ppa),
        .trnsl_fault (trnsl_fault),
        .att_raddr   (att_raddr),
        .att_we      (lk_att_we),
        .att_waddr   (lk_att_waddr),
        .att_wsts    (lk_att_wsts),
        .att_wppa    (lk_att_wppa),
        .fl_pop      (fl_pop),
        .att_rsts    (att_rsts),
        .att_rppa    (att_rppa),
        .fl_rdata    (fl_rdata),
        .fl_empty    (fl_empty)
    );

    hawk_att_store #(.HPPA_W(HPPA_W), .PPA_W(PPA_W), .NUM_PAGES(NUM_PAGES)) i_store (.*);

    hawk_pg_writer #(.HPPA_W(HPPA_W), .PPA_W(PPA_W), .NUM_PAGES(NUM_PAGES)) i_pg_writer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_att       (init_att),
        .init_list      (init_list),
        .init_att_done  (init_att_done),
        .init_list_done (init_list_done),
        .att_we         (pw_att_we),
        .att_waddr      (pw_att_waddr),
        .att_wsts       (pw_att_wsts),
        .att_wppa       (pw_att_wppa),
        .fl_push        (fl_push),
        .fl_wdata       (fl_wdata)
    );

    // page writer owns the ATT write port until both sweeps end
    assign init_done = init_att_done && init_list_done;
    assign att_we    = init_done ? lk_att_we    : pw_att_we;
    assign att_waddr = init_done ? lk_att_waddr : pw_att_waddr;
    assign att_wsts  = init_done ? lk_att_wsts  : pw_att_wsts;
    assign att_wppa  = init_done ? lk_att_wppa  : pw_att_wppa;

endmodule

// File: tests/hawk_asserts.sv
// hawk protocol checks, bound into the top level
`timescale 1ns/1ps

module hawk_asserts import hawk_pkg::*; (
    input logic      clk_i,
    input logic      rst_ni,
    input logic      rd_ack,
    input logic      rd_err,
    input logic      wr_ack,
    input logic      wr_err,
    input logic      init_list,
    input logic      lkup_req,
    input cu_state_e cu_state
);

    //////////////////////////////////////////////////////////////////////
    // wishbone responses
    //////////////////////////////////////////////////////////////////////

    // never ack and err together
    a_rd_excl: assert property (@(posedge clk_i) disable iff (!rst_ni) !(rd_ack && rd_err))
        else $error("read port drives ack and err together");
    a_wr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni) !(wr_ack && wr_err))
        else $error("write port drives ack and err together");

    // single cycle strobes
    a_rd_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rd_ack || rd_err) |=> !(rd_ack || rd_err))
        else $error("read port response longer than one cycle");
    a_wr_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wr_ack || wr_err) |=> !(wr_ack || wr_err))
        else $error("write port response longer than one cycle");

    //////////////////////////////////////////////////////////////////////
    // init sequencing
    //////////////////////////////////////////////////////////////////////

    // free list still filling
    a_no_lkup_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(lkup_req && init_list))
        else $error("lookup issued while the free list is still being filled");

    // stalled requests get no answer
    a_no_ack_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (cu_state == IDLE) |-> !(rd_ack || wr_ack))
        else $error("cpu port acked while control unit is idle");

endmodule

bind hawk_top hawk_asserts i_asserts (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_ack    (rd_ack),
    .rd_err    (rd_err),
    .wr_ack    (wr_ack),
    .wr_err    (wr_err),
    .init_list (init_list),
    .lkup_req  (lkup_req),
    .cu_state  (cu_state)
);

// File: tests/hawk_tb.sv
// hawk testbench driving table based Wishbone accesses on both cpu ports
`timescale 1ns/1ps

module hawk_tb import hawk_pkg::*; ();

    localparam int TB_HPPA_W   = 4;
    localparam int TB_PPA_W    = 6;
    localparam int TB_PAGES    = 4;
    // ATT sweep length
    localparam int INIT_CYCLES = 2 ** TB_HPPA_W;
    localparam int TIMEOUT_CYC = 200;
    localparam int MAX_ENTRIES = 16;
    localparam bit PORT_RD     = 1'b0;
    localparam bit PORT_WR     = 1'b1;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 rd_cyc, rd_stb, rd_ack, rd_err;
    logic [TB_HPPA_W-1:0] rd_adr;
    logic [TB_PPA_W-1:0]  rd_dat_r;
    logic                 wr_cyc, wr_stb, wr_ack, wr_err;
    logic [TB_HPPA_W-1:0] wr_adr;
    logic [31:0]          wr_dat_w;
    logic [TB_PPA_W-1:0]  wr_dat_r;
    cu_state_e            cu_state;

    // stimulus table
    string                t_name    [MAX_ENTRIES];
    bit                   t_port    [MAX_ENTRIES];
    logic [TB_HPPA_W-1:0] t_hppa    [MAX_ENTRIES];
    logic [31:0]          t_dat     [MAX_ENTRIES];
    logic [TB_PPA_W-1:0]  t_ppa     [MAX_ENTRIES];
    bit                   t_err     [MAX_ENTRIES];
    bit                   t_pair    [MAX_ENTRIES];
    int                   t_min_lat [MAX_ENTRIES];
    int                   n_entries;
    int                   idx;

    hawk_top #(.HPPA_W(TB_HPPA_W), .PPA_W(TB_PPA_W), .NUM_PAGES(TB_PAGES)) i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic add_entry(input string name, input bit port, input int hppa, input int dat,
                             input int ppa, input bit err, input bit pair, input int min_lat);
        t_name[n_entries]    = name;
        t_port[n_entries]    = port;
        t_hppa[n_entries]    = TB_HPPA_W'(hppa);
        t_dat[n_entries]     = 32'(dat);
        t_ppa[n_entries]     = TB_PPA_W'(ppa);
        t_err[n_entries]     = err;
        t_pair[n_entries]    = pair;
        t_min_lat[n_entries] = min_lat;
        n_entries            = n_entries + 1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // table entries where free pages come off the list as 1 then 2 then 3
    //////////////////////////////////////////////////////////////////////

    task automatic build_table();
        //        name             port     hppa dat    ppa err pair lat
        add_entry("wr_first",      PORT_WR, 2,  'h1234, 1, 0, 0, INIT_CYCLES);
        add_entry("rd_mapped",     PORT_RD, 2,  0,      1, 0, 0, 0);
        add_entry("wr_zero",       PORT_WR, 5,  0,      0, 0, 0, 0);
        add_entry("rd_zero",       PORT_RD, 5,  0,      0, 0, 0, 0);
        add_entry("wr_after_zero", PORT_WR, 5,  'ha5,   2, 0, 0, 0);
        add_entry("wr_rewrite",    PORT_WR, 2,  'h77,   1, 0, 0, 0);
        add_entry("wr_third",      PORT_WR, 9,  1,      3, 0, 0, 0);
        add_entry("wr_full",       PORT_WR, 11, 2,      0, 1, 0, 0);
        add_entry("wr_zero_full",  PORT_WR, 12, 0,      0, 0, 0, 0);
        add_entry("rd_still_map",  PORT_RD, 9,  0,      3, 0, 0, 0);
        add_entry("wr_still_map",  PORT_WR, 5,  3,      2, 0, 0, 0);
        // both ports at once
        add_entry("pair_a_rd",     PORT_RD, 2,  0,      1, 0, 1, 0);
        add_entry("pair_a_wr",     PORT_WR, 9,  5,      3, 0, 1, 0);
        add_entry("pair_b_rd",     PORT_RD, 5,  0,      2, 0, 1, 0);
        add_entry("pair_b_wr",     PORT_WR, 14, 'h10,   0, 1, 1, 0);
    endtask

    // one Wishbone classic cycle driven and sampled on the falling edge
    task automatic wb_access(input int n);
        int                  waited;
        logic                got_ack;
        logic                got_err;
        logic [TB_PPA_W-1:0] got_ppa;
        waited  = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        @(negedge clk_i);
        if (t_port[n] == PORT_RD) begin
            rd_adr = t_hppa[n];
            rd_cyc = 1'b1;
            rd_stb = 1'b1;
        end else begin
            wr_adr   = t_hppa[n];
            wr_dat_w = t_dat[n];
            wr_cyc   = 1'b1;
            wr_stb   = 1'b1;
        end
        while (!got_ack && !got_err) begin
            @(negedge clk_i);
            waited = waited + 1;
            got_ack = (t_port[n] == PORT_RD) ? rd_ack : wr_ack;
            got_err = (t_port[n] == PORT_RD) ? rd_err : wr_err;
            got_ppa = (t_port[n] == PORT_RD) ? rd_dat_r : wr_dat_r;
            if (!got_ack && !got_err && waited > TIMEOUT_CYC) begin
                report_failure($sformatf("no ack or err for %s after %0d cycles",
                                         t_name[n], waited));
            end
        end
        // close the cycle
        if (t_port[n] == PORT_RD) begin
            rd_cyc = 1'b0;
            rd_stb = 1'b0;
        end else begin
            wr_cyc = 1'b0;
            wr_stb = 1'b0;
        end
        assert (got_err == t_err[n]) else
            report_failure($sformatf("ERR %s err expected %0b actual %0b",
                                     t_name[n], t_err[n], got_err));
        if (!t_err[n]) begin
            assert (got_ppa == t_ppa[n]) else
                report_failure($sformatf("ERR %s ppa expected %0d actual %0d",
                                         t_name[n], t_ppa[n], got_ppa));
        end
        // stalled behind init
        if (t_min_lat[n] > 0) begin
            assert (waited >= t_min_lat[n]) else
                report_failure($sformatf("ERR %s latency expected >= %0d actual %0d",
                                         t_name[n], t_min_lat[n], waited));
        end
    endtask

    task automatic run_pair(input int a, input int b);
        fork
            wb_access(a);
            wb_access(b);
        join
    endtask

    initial begin
        rst_ni    = 1'b0;
        rd_cyc    = 1'b0;
        rd_stb    = 1'b0;
        rd_adr    = '0;
        wr_cyc    = 1'b0;
        wr_stb    = 1'b0;
        wr_adr    = '0;
        wr_dat_w  = '0;
        n_entries = 0;
        build_table();
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;
        idx = 0;
        while (idx < n_entries) begin
            if (t_pair[idx] && idx + 1 < n_entries) begin
                run_pair(idx, idx + 1);
                idx = idx + 2;
            end else begin
                wb_access(idx);
                idx = idx + 1;
            end
        end
        repeat (2) @(negedge clk_i);
        $display("** PASS **");
        $finish;
    end

endmodule

// File: verilog.f
common/hawk_pkg.sv
src/hawk_cpu_port.sv
ctrl/hawk_ctrl_unit.sv
att/hawk_att_lookup.sv
att/hawk_att_store.sv
src/hawk_pg_writer.sv
src/hawk_top.sv
tests/hawk_asserts.sv
tests/hawk_tb.sv

// File: Makefile
# Verilator build and run for the hawk page translation engine

TOP      ?= hawk_tb
FLIST    ?= verilog.f
OBJ_DIR  ?= obj_dir
VERILATOR ?= verilator
VFLAGS   ?= --binary --timing --assert -Wno-fatal
PASS_MSG := ** PASS **

SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the simulation output is shown, then searched for the pass line
run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
